//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_box_filter
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
verilog/img_geom_pkg.sv
verilog/filter_pkg.sv
verilog/line_buffer_bank.sv
verilog/window_buffer_datapath.sv
verilog/box_sum_tree.sv
verilog/box_filter_top.sv
verif/box_filter_assertions.sv
verif/box_filter_checker.sv
verif/tb_box_filter.sv

//--- verif/box_filter_assertions.sv
`timescale 1ns/1ps

module box_filter_assertions (
  input logic clk,
  input logic rst_n,
  input logic col_valid_i,
  input logic window_valid_i,
  input logic sum_valid_i,
  input logic frame_done_i
);

  int failures;

  // A reset cycle clears every strobe by the next edge.
  reset_clears_strobes: assert property (@(posedge clk)
    !rst_n |=> !col_valid_i && !window_valid_i && !sum_valid_i && !frame_done_i)
    else begin
      $error("strobe still high one cycle after reset");
      failures++;
    end

  // Two register stages in the sum tree.
  sum_follows_window: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid_i == $past(window_valid_i, 2))
    else begin
      $error("sum_valid_o does not follow window_valid by two cycles");
      failures++;
    end

  frame_done_single: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done_i |=> !frame_done_i)
    else begin
      $error("frame_done_o held for more than one cycle");
      failures++;
    end

endmodule

bind box_filter_top box_filter_assertions u_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .col_valid_i    (col_valid),
  .window_valid_i (window_valid),
  .sum_valid_i    (sum_valid_o),
  .frame_done_i   (frame_done_o)
);

//--- verif/box_filter_checker.sv
`timescale 1ns/1ps

module box_filter_checker (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         pixel_valid_i,
  input logic [filter_pkg::SUM_W-1:0] sum_i,
  input logic                         sum_valid_i,
  input logic                         frame_done_i
);

  import img_geom_pkg::*;
  import filter_pkg::*;

  // Cycles from a sampled strobe to the sampled output.
  localparam int SUM_LATENCY  = 4;
  localparam int DONE_LATENCY = 2;

  int unsigned      cycle;
  int               col;
  int               row;
  int               error_count;
  int               check_count;
  int               sum_count;
  int               frame_count;

  logic [SUM_W-1:0] exp_sum_q  [$];
  int unsigned      sum_due_q  [$];
  int unsigned      done_due_q [$];

  task automatic push_expected(input logic [SUM_W-1:0] value);
    exp_sum_q.push_back(value);
  endtask

  function automatic bit all_drained();
    return (exp_sum_q.size() == 0) && (sum_due_q.size() == 0) && (done_due_q.size() == 0);
  endfunction

  task automatic check_sum();
    logic [SUM_W-1:0] expected;
    int unsigned      due;
    if (exp_sum_q.size() == 0) begin
      error_count++;
      $display("unexpected sum %0d at %0d ns, no expected sum is left", sum_i, $time);
    end else begin
      expected = exp_sum_q.pop_front();
      check_count++;
      if (sum_i !== expected) begin
        error_count++;
        $display("CHECK FAILED at %0d ns: sum %0d expected %0d, got %0d",
                 $time, sum_count, expected, sum_i);
      end
    end
    if (sum_due_q.size() == 0) begin
      error_count++;
      $display("sum_valid_o at %0d ns before any complete window", $time);
    end else begin
      due = sum_due_q.pop_front();
      check_count++;
      if (cycle != due) begin
        error_count++;
        $display("CHECK FAILED at %0d ns: sum %0d in cycle %0d, expected cycle %0d",
                 $time, sum_count, cycle, due);
      end
    end
    sum_count++;
  endtask

  task automatic check_frame_done();
    int unsigned due;
    if (done_due_q.size() == 0) begin
      error_count++;
      $display("frame_done_o at %0d ns without a finished frame", $time);
    end else begin
      due = done_due_q.pop_front();
      check_count++;
      if (cycle != due) begin
        error_count++;
        $display("CHECK FAILED at %0d ns: frame_done in cycle %0d, expected cycle %0d",
                 $time, cycle, due);
      end
    end
    frame_count++;
  endtask

  // Position of the accepted pixel in its frame.
  task automatic track_pixel();
    if (col >= WIN_SIZE - 1 && row >= WIN_SIZE - 1) begin
      sum_due_q.push_back(cycle + SUM_LATENCY);
    end
    if (col == IMG_COLS - 1 && row == IMG_ROWS - 1) begin
      done_due_q.push_back(cycle + DONE_LATENCY);
    end
    if (col == IMG_COLS - 1) begin
      col = 0;
      row = (row == IMG_ROWS - 1) ? 0 : row + 1;
    end else begin
      col++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      col = 0;
      row = 0;
    end else begin
      if (sum_valid_i) begin
        check_sum();
      end
      if (frame_done_i) begin
        check_frame_done();
      end
      if (pixel_valid_i) begin
        track_pixel();
      end
    end
    cycle++;
  end

endmodule

//--- verif/box_filter_golden.txt
// Per frame: 12 rows of 14 pixels in hex, raster order.
// Then the frame's 8 window sums in hex, raster order of the window's bottom-right corner.
// Frame 0
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d
30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d
50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d
60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d
70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d
80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d
90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad
b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd
282d 28a6 291f 2998
2fbd 3036 30af 3128
// Frame 1
ff fe fd fc fb fa f9 f8 f7 f6 f5 f4 f3 f2
ef ee ed ec eb ea e9 e8 e7 e6 e5 e4 e3 e2
df de dd dc db da d9 d8 d7 d6 d5 d4 d3 d2
cf ce cd cc cb ca c9 c8 c7 c6 c5 c4 c3 c2
bf be bd bc bb ba b9 b8 b7 b6 b5 b4 b3 b2
af ae ad ac ab aa a9 a8 a7 a6 a5 a4 a3 a2
9f 9e 9d 9c 9b 9a 99 98 97 96 95 94 93 92
8f 8e 8d 8c 8b 8a 89 88 87 86 85 84 83 82
7f 7e 7d 7c 7b 7a 79 78 77 76 75 74 73 72
6f 6e 6d 6c 6b 6a 69 68 67 66 65 64 63 62
5f 5e 5d 5c 5b 5a 59 58 57 56 55 54 53 52
4f 4e 4d 4c 4b 4a 49 48 47 46 45 44 43 42
505a 4fe1 4f68 4eef
48ca 4851 47d8 475f

//--- verif/tb_box_filter.sv
`timescale 1ns/1ps

module tb_box_filter;

  import img_geom_pkg::*;
  import filter_pkg::*;

  localparam int FRAME_PIX   = IMG_COLS * IMG_ROWS;
  localparam int FRAME_SUMS  = (IMG_COLS - WIN_SIZE + 1) * (IMG_ROWS - WIN_SIZE + 1);
  localparam int FRAME_WORDS = FRAME_PIX + FRAME_SUMS;
  localparam int NUM_FRAMES  = 2;
  localparam int WAIT_LIMIT  = 200;

  logic             clk;
  logic             rst_n;
  logic [PIX_W-1:0] pixel;
  logic             pixel_valid;
  logic [SUM_W-1:0] sum;
  logic             sum_valid;
  logic             frame_done;

  logic [15:0]      golden_mem [NUM_FRAMES*FRAME_WORDS];
  int               timeout_count;
  bit               run_ok;

  box_filter_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel),
    .pixel_valid_i (pixel_valid),
    .sum_o         (sum),
    .sum_valid_o   (sum_valid),
    .frame_done_o  (frame_done)
  );

  box_filter_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_valid_i (pixel_valid),
    .sum_i         (sum),
    .sum_valid_i   (sum_valid),
    .frame_done_i  (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic load_expected();
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int s = 0; s < FRAME_SUMS; s++) begin
        u_checker.push_expected(golden_mem[f*FRAME_WORDS + FRAME_PIX + s][SUM_W-1:0]);
      end
    end
  endtask

  // Starts and ends 1 ns after a rising edge.
  task automatic send_frame(input int frame, input bit with_gaps);
    int base;
    int gap;
    base = frame * FRAME_WORDS;
    for (int i = 0; i < FRAME_PIX; i++) begin
      pixel       = golden_mem[base + i][PIX_W-1:0];
      pixel_valid = 1'b1;
      @(posedge clk);
      #1;
      gap = 0;
      if (with_gaps) begin
        gap = $urandom_range(3, 0);
      end
      if (gap > 0) begin
        pixel_valid = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
    end
    pixel_valid = 1'b0;
  endtask

  task automatic wait_for_frames(input int frames);
    int waited;
    waited = 0;
    while (u_checker.frame_count < frames && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (u_checker.frame_count < frames) begin
      $display("timeout waiting for frame_done, %0d of %0d frames seen",
               u_checker.frame_count, frames);
      timeout_count++;
      run_ok = 1'b0;
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (!u_checker.all_drained() && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!u_checker.all_drained()) begin
      $display("timeout waiting for the last sums to come out");
      timeout_count++;
      run_ok = 1'b0;
    end
  endtask

  task automatic report_and_finish();
    int errors;
    int checks;
    errors = u_checker.error_count + DUT.u_assertions.failures + timeout_count;
    checks = u_checker.check_count + 1;
    if (u_checker.sum_count != NUM_FRAMES * FRAME_SUMS) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %0d sums seen, expected %0d",
               $time, u_checker.sum_count, NUM_FRAMES * FRAME_SUMS);
    end
    $display("errors: %0d  checks: %0d  timeouts: %0d", errors, checks, timeout_count);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  initial begin
    rst_n         = 1'b0;
    pixel         = '0;
    pixel_valid   = 1'b0;
    timeout_count = 0;
    run_ok        = 1'b1;
    void'($urandom(32'hd920));
    $readmemh("verif/box_filter_golden.txt", golden_mem);
    load_expected();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle stretch with quiet outputs.
    repeat (6) @(posedge clk);
    #1;
    send_frame(0, 1'b0);
    send_frame(1, 1'b1);
    wait_for_frames(NUM_FRAMES);
    if (run_ok) begin
      wait_for_drain();
    end
    report_and_finish();
  end

endmodule

//--- verilog/box_filter_top.sv
`timescale 1ns/1ps

module box_filter_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [filter_pkg::PIX_W-1:0] pixel_i,
  input  logic                         pixel_valid_i,
  output logic [filter_pkg::SUM_W-1:0] sum_o,
  output logic                         sum_valid_o,
  output logic                         frame_done_o
);

  import img_geom_pkg::*;
  import filter_pkg::*;

  logic [WIN_SIZE*PIX_W-1:0] col_pix;
  logic                      col_valid;
  logic [WIN_PIX*PIX_W-1:0]  window;
  logic                      window_valid;

  line_buffer_bank u_line_buffer_bank (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .col_pix_o     (col_pix),
    .col_valid_o   (col_valid)
  );

  window_buffer_datapath u_window_buffer_datapath (
    .clk            (clk),
    .rst_n          (rst_n),
    .col_pix_i      (col_pix),
    .col_valid_i    (col_valid),
    .window_o       (window),
    .window_valid_o (window_valid),
    .frame_done_o   (frame_done_o)
  );

  box_sum_tree u_box_sum_tree (
    .clk            (clk),
    .rst_n          (rst_n),
    .window_i       (window),
    .window_valid_i (window_valid),
    .sum_o          (sum_o),
    .sum_valid_o    (sum_valid_o)
  );

endmodule

//--- verilog/box_sum_tree.sv
`timescale 1ns/1ps

module box_sum_tree (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [filter_pkg::WIN_PIX*filter_pkg::PIX_W-1:0] window_i,
  input  logic                                             window_valid_i,
  output logic [filter_pkg::SUM_W-1:0]                     sum_o,
  output logic                                             sum_valid_o
);

  import img_geom_pkg::*;
  import filter_pkg::*;

  logic [ROW_SUM_W-1:0] row_sum_d [WIN_SIZE];
  logic [ROW_SUM_W-1:0] row_sum_q [WIN_SIZE];
  logic [SUM_W-1:0]     total_d;
  logic                 stage1_valid_q;

  // Stage one, eleven independent row sums.
  always_comb begin
    for (int r = 0; r < WIN_SIZE; r++) begin
      row_sum_d[r] = '0;
      for (int c = 0; c < WIN_SIZE; c++) begin
        row_sum_d[r] = row_sum_d[r] +
                       ROW_SUM_W'(window_i[(r*WIN_SIZE+c)*PIX_W +: PIX_W]);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < WIN_SIZE; r++) begin
      row_sum_q[r] <= row_sum_d[r];
    end
  end

  // Stage two adds the registered row sums.
  always_comb begin
    total_d = '0;
    for (int r = 0; r < WIN_SIZE; r++) begin
      total_d = total_d + SUM_W'(row_sum_q[r]);
    end
  end

  always_ff @(posedge clk) begin
    sum_o <= total_d;
  end

  // Valid bits march with the data so back to back windows are kept apart.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage1_valid_q <= 1'b0;
      sum_valid_o    <= 1'b0;
    end else begin
      stage1_valid_q <= window_valid_i;
      sum_valid_o    <= stage1_valid_q;
    end
  end

endmodule

//--- verilog/filter_pkg.sv
package filter_pkg;

  // Grayscale pixel.
  localparam int PIX_W = 8;

  // Eleven pixels of one window row fit in 12 bits.
  localparam int ROW_SUM_W = 12;

  // The sum of all 121 pixels fits in 15 bits.
  localparam int SUM_W = 15;

  localparam int WIN_PIX = 121;

endpackage

//--- verilog/img_geom_pkg.sv
package img_geom_pkg;

  // Frame size in pixels.
  localparam int IMG_COLS = 14;
  localparam int IMG_ROWS = 12;

  // Edge of the square filter window.
  localparam int WIN_SIZE = 11;

  // Counter widths, wide enough for IMG_COLS and IMG_ROWS.
  localparam int COL_W = 4;
  localparam int ROW_W = 4;

endpackage

//--- verilog/line_buffer_bank.sv
`timescale 1ns/1ps

module line_buffer_bank (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [filter_pkg::PIX_W-1:0]                        pixel_i,
  input  logic                                                pixel_valid_i,
  output logic [img_geom_pkg::WIN_SIZE*filter_pkg::PIX_W-1:0] col_pix_o,
  output logic                                                col_valid_o
);

  import img_geom_pkg::*;
  import filter_pkg::*;

  // One delay line per previous row. Index IMG_COLS-1 holds the oldest pixel.
  logic [PIX_W-1:0] line_q [WIN_SIZE-1][IMG_COLS];

  // Lines shift only on an accepted pixel, so gaps simply stall the bank.
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      for (int k = 0; k < WIN_SIZE - 1; k++) begin
        for (int j = IMG_COLS - 1; j > 0; j--) begin
          line_q[k][j] <= line_q[k][j-1];
        end
      end
      line_q[0][0] <= pixel_i;
      // Each line feeds the next one, one row further back.
      for (int k = 1; k < WIN_SIZE - 1; k++) begin
        line_q[k][0] <= line_q[k-1][IMG_COLS-1];
      end
    end
  end

  // Newest slot gets the current pixel, slot 0 the pixel ten rows above.
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      col_pix_o[(WIN_SIZE-1)*PIX_W +: PIX_W] <= pixel_i;
      for (int k = 0; k < WIN_SIZE - 1; k++) begin
        col_pix_o[(WIN_SIZE-2-k)*PIX_W +: PIX_W] <= line_q[k][IMG_COLS-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_valid_o <= 1'b0;
    end else begin
      col_valid_o <= pixel_valid_i;
    end
  end

endmodule

//--- verilog/window_buffer_datapath.sv
`timescale 1ns/1ps

module window_buffer_datapath (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [img_geom_pkg::WIN_SIZE*filter_pkg::PIX_W-1:0]  col_pix_i,
  input  logic                                                 col_valid_i,
  output logic [filter_pkg::WIN_PIX*filter_pkg::PIX_W-1:0]     window_o,
  output logic                                                 window_valid_o,
  output logic                                                 frame_done_o
);

  import img_geom_pkg::*;
  import filter_pkg::*;

  // Window storage, row 0 is the oldest row and column 0 the oldest column.
  logic [PIX_W-1:0] win_q [WIN_SIZE][WIN_SIZE];

  // Position of the column that arrives with col_valid_i.
  logic [COL_W-1:0] col_cnt_q;
  logic [ROW_W-1:0] row_cnt_q;

  logic             col_last;
  logic             row_last;
  logic             win_full;

  assign col_last = (col_cnt_q == COL_W'(IMG_COLS - 1));
  assign row_last = (row_cnt_q == ROW_W'(IMG_ROWS - 1));

  // Full window once both counters have reached the window edge.
  assign win_full = (col_cnt_q >= COL_W'(WIN_SIZE - 1)) &&
                    (row_cnt_q >= ROW_W'(WIN_SIZE - 1));

  always_ff @(posedge clk) begin
    if (col_valid_i) begin
      for (int r = 0; r < WIN_SIZE; r++) begin
        for (int c = 0; c < WIN_SIZE - 1; c++) begin
          win_q[r][c] <= win_q[r][c+1];
        end
        win_q[r][WIN_SIZE-1] <= col_pix_i[r*PIX_W +: PIX_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt_q <= '0;
      row_cnt_q <= '0;
    end else if (col_valid_i) begin
      if (col_last) begin
        col_cnt_q <= '0;
        // Row counter wraps with the frame.
        if (row_last) begin
          row_cnt_q <= '0;
        end else begin
          row_cnt_q <= row_cnt_q + 1'b1;
        end
      end else begin
        col_cnt_q <= col_cnt_q + 1'b1;
      end
    end
  end

  // Both flags come out with the window that they describe.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      window_valid_o <= 1'b0;
      frame_done_o   <= 1'b0;
    end else begin
      window_valid_o <= col_valid_i && win_full;
      frame_done_o   <= col_valid_i && col_last && row_last;
    end
  end

  for (genvar r = 0; r < WIN_SIZE; r++) begin : g_row
    for (genvar c = 0; c < WIN_SIZE; c++) begin : g_col
      assign window_o[(r*WIN_SIZE+c)*PIX_W +: PIX_W] = win_q[r][c];
    end
  end

endmodule
